// ==== all.f ====
+incdir+include
logic/rom_check_pkg.sv
logic/rom_check_regs.sv
logic/compare_fsm.sv
logic/word_counter.sv
logic/digest_matcher.sv
logic/rom_check_top.sv
verification/rom_check_tb.sv

// ==== Bender.yml ====
package:
  name: rom_check

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/rom_check_pkg.sv
      - logic/rom_check_regs.sv
      - logic/compare_fsm.sv
      - logic/word_counter.sv
      - logic/digest_matcher.sv
      - logic/rom_check_top.sv
      - target: test
        files:
          - verification/rom_check_tb.sv

// ==== verification/rom_check_tb.sv ====
/*
 * Testbench for the ROM digest checker
 * APB register traffic, digest checks, alert and read-back behavior
 */

`timescale 1ns/100ps
`default_nettype none

`include "rom_check_config.svh"

module rom_check_tb import rom_check_pkg::*; ();

  localparam int NumWords = `ROM_CHECK_NUM_WORDS;
  localparam int AddrW    = `ROM_CHECK_ADDR_W;
  localparam int NumTests = 5;
  // Reset, worst-case APB traffic of 3 cycles per access, one digest check
  localparam int TestCycles = 4 + 3 * (4 * NumWords + 6) + (NumWords + 3);
  localparam int Margin     = 50;

  logic             clk_i;
  logic             rst_ni;
  logic [AddrW-1:0] paddr_i;
  logic             psel_i;
  logic             penable_i;
  logic             pwrite_i;
  logic [31:0]      pwdata_i;
  logic [31:0]      prdata_o;
  logic             pready_o;
  logic             pslverr_o;
  logic             done_o;
  mubi4_t           good_o;
  logic             alert_o;

  integer      seed;
  int          errors;
  int          errs_at_start;
  int          tests_passed;
  int          tests_failed;
  logic [31:0] dig_words [NumWords];
  logic [31:0] exp_words [NumWords];

  rom_check_top u_dut (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .done_o    (done_o),
    .good_o    (good_o),
    .alert_o   (alert_o)
  );

  // 100 ns clock
  always #50 clk_i = ~clk_i;

  // Ends a hung run
  initial begin
    #((NumTests * TestCycles + Margin) * 100);
    $display("Watchdog expired before all tests completed");
    $display("Test failures found");
    $finish;
  end

  // STATUS layout: done at bit 0, good at 7:4, alert at bit 8
  function automatic logic [31:0] status_word(logic done, mubi4_t good, logic alert);
    return (32'(alert) << 8) | (32'(good) << 4) | 32'(done);
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  task automatic apply_reset();
    @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b0;
  endtask

  // Starts on a falling edge with the setup phase
  // Response sampled mid access phase, idle on return
  task automatic access_reg(input logic wr, input logic [AddrW-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    paddr_i   = addr;
    pwdata_i  = wdata;
    pwrite_i  = wr;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    @(negedge clk_i);
    penable_i = 1'b1;
    #25;
    rdata = prdata_o;
    err   = pslverr_o;
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  // Writes random words, word bad_pos of the expected digest differs
  task automatic load_words(input int bad_pos);
    logic [31:0] unused;
    logic        err;
    for (int i = 0; i < NumWords; i++) begin
      dig_words[i] = $random(seed);
      exp_words[i] = (i == bad_pos) ? dig_words[i] ^ ($random(seed) | 32'h1) : dig_words[i];
      access_reg(1'b1, `ROM_CHECK_DIGEST_OFFS + 4 * i, dig_words[i], unused, err);
      access_reg(1'b1, `ROM_CHECK_EXP_OFFS + 4 * i, exp_words[i], unused, err);
    end
  endtask

  // Counts falling edges until done, bounded
  task automatic wait_done(output int cycles);
    cycles = 0;
    while (!done_o && cycles < NumWords + 5) begin
      @(negedge clk_i);
      cycles++;
    end
    assert (done_o) else begin
      $display("done_o never rose after the start write");
      errors++;
    end
  endtask

  // Start write, then count cycles from the start pulse to done
  task automatic run_check(output int cycles);
    logic [31:0] unused;
    logic        err;
    access_reg(1'b1, `ROM_CHECK_CTRL_OFFS, 32'h1, unused, err);
    compare_value("start_o", u_dut.u_regs.start_o, 1'b1);
    wait_done(cycles);
  endtask

  task automatic end_test(input string name);
    if (errors == errs_at_start) begin
      tests_passed++;
      $display("%s: PASS", name);
    end else begin
      tests_failed++;
      $display("%s: FAIL", name);
    end
    errs_at_start = errors;
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    int          cycles;
    int          bad_pos;
    clk_i = 1'b0;
    rst_ni = 1'b1;
    paddr_i = '0;
    psel_i = 1'b0;
    penable_i = 1'b0;
    pwrite_i = 1'b0;
    pwdata_i = '0;
    seed = 32'ha7ad;
    errors = 0;
    errs_at_start = 0;
    tests_passed = 0;
    tests_failed = 0;

    // Reset values and STATUS
    apply_reset();
    compare_value("done_o", done_o, 1'b0);
    compare_value("alert_o", alert_o, 1'b0);
    compare_value("good_o", good_o, MuBi4False);
    compare_value("pready_o", pready_o, 1'b1);
    access_reg(1'b0, `ROM_CHECK_STATUS_OFFS, '0, rdata, err);
    compare_value("STATUS", rdata, status_word(1'b0, MuBi4False, 1'b0));
    end_test("reset_values");

    // Equal digests pass
    apply_reset();
    load_words(-1);
    run_check(cycles);
    compare_value("done latency", cycles, NumWords + 1);
    @(negedge clk_i);
    compare_value("good_o", good_o, MuBi4True);
    access_reg(1'b0, `ROM_CHECK_STATUS_OFFS, '0, rdata, err);
    compare_value("STATUS", rdata, status_word(1'b1, MuBi4True, 1'b0));
    compare_value("alert_o", alert_o, 1'b0);
    end_test("equal_digest");

    // One differing word fails
    apply_reset();
    bad_pos = {$random(seed)} % NumWords;
    load_words(bad_pos);
    run_check(cycles);
    repeat (2) @(negedge clk_i);
    compare_value("good_o", good_o, MuBi4False);
    compare_value("alert_o", alert_o, 1'b0);
    end_test("word_mismatch");

    // Second start during Checking
    apply_reset();
    load_words(-1);
    access_reg(1'b1, `ROM_CHECK_CTRL_OFFS, 32'h1, rdata, err);
    // Back to back, so the pulse lands one cycle into Checking
    access_reg(1'b1, `ROM_CHECK_CTRL_OFFS, 32'h1, rdata, err);
    wait_done(cycles);
    repeat (4) @(negedge clk_i);
    compare_value("alert_o", alert_o, 1'b1);
    compare_value("done_o", done_o, 1'b1);
    // Sticky until reset, then a start in Done
    apply_reset();
    compare_value("alert_o", alert_o, 1'b0);
    load_words(-1);
    run_check(cycles);
    @(negedge clk_i);
    compare_value("alert_o", alert_o, 1'b0);
    access_reg(1'b1, `ROM_CHECK_CTRL_OFFS, 32'h1, rdata, err);
    repeat (2) @(negedge clk_i);
    compare_value("alert_o", alert_o, 1'b1);
    compare_value("done_o", done_o, 1'b1);
    end_test("restart_alert");

    // Read-back and unmapped offsets
    apply_reset();
    load_words(-1);
    access_reg(1'b1, 8'h08, 32'hffff_ffff, rdata, err);
    compare_value("pslverr_o", err, 1'b1);
    access_reg(1'b1, 8'hfc, 32'hffff_ffff, rdata, err);
    compare_value("pslverr_o", err, 1'b1);
    access_reg(1'b0, 8'hfc, '0, rdata, err);
    compare_value("pslverr_o", err, 1'b1);
    for (int i = 0; i < NumWords; i++) begin
      access_reg(1'b0, `ROM_CHECK_DIGEST_OFFS + 4 * i, '0, rdata, err);
      compare_value("DIGEST", rdata, dig_words[i]);
      compare_value("pslverr_o", err, 1'b0);
      access_reg(1'b0, `ROM_CHECK_EXP_OFFS + 4 * i, '0, rdata, err);
      compare_value("EXP_DIGEST", rdata, exp_words[i]);
    end
    access_reg(1'b0, `ROM_CHECK_STATUS_OFFS, '0, rdata, err);
    compare_value("STATUS", rdata, status_word(1'b0, MuBi4False, 1'b0));
    end_test("readback_unmapped");

    $display("%0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== logic/rom_check_top.sv ====
/*
 * ROM digest checker top level
 * Register block, sequencer, redundant counter and matcher
 */

`timescale 1ns/100ps
`default_nettype none

`include "rom_check_config.svh"

module rom_check_top import rom_check_pkg::*; (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire logic [`ROM_CHECK_ADDR_W-1:0]  paddr_i,
  input  wire logic                          psel_i,
  input  wire logic                          penable_i,
  input  wire logic                          pwrite_i,
  input  wire logic [31:0]                   pwdata_i,
  output logic      [31:0]                   prdata_o,
  output logic                               pready_o,
  output logic                               pslverr_o,
  output logic                               done_o,
  output mubi4_t                             good_o,
  output logic                               alert_o
);

  logic                                   start;
  logic                                   incr;
  logic                                   checking;
  logic                                   cnt_err;
  logic [`ROM_CHECK_CNT_W-1:0]            idx;
  logic [`ROM_CHECK_NUM_WORDS*32-1:0]     digest;
  logic [`ROM_CHECK_NUM_WORDS*32-1:0]     exp_digest;

  // APB slave and digest storage
  rom_check_regs u_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .paddr_i      (paddr_i),
    .psel_i       (psel_i),
    .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),
    .pwdata_i     (pwdata_i),
    .prdata_o     (prdata_o),
    .pready_o     (pready_o),
    .pslverr_o    (pslverr_o),
    .done_i       (done_o),
    .good_i       (good_o),
    .alert_i      (alert_o),
    .start_o      (start),
    .digest_o     (digest),
    .exp_digest_o (exp_digest)
  );

  compare_fsm u_fsm (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start),
    .idx_i      (idx),
    .cnt_err_i  (cnt_err),
    .incr_o     (incr),
    .checking_o (checking),
    .done_o     (done_o),
    .alert_o    (alert_o)
  );

  word_counter u_counter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .incr_i (incr),
    .idx_o  (idx),
    .err_o  (cnt_err)
  );

  digest_matcher u_matcher (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .checking_i   (checking),
    .idx_i        (idx),
    .digest_i     (digest),
    .exp_digest_i (exp_digest),
    .good_o       (good_o)
  );

endmodule

`default_nettype wire

// ==== logic/digest_matcher.sv ====
/*
 * Digest word matcher
 * Compares the selected word pair and encodes the multi-bit good result
 */

`timescale 1ns/100ps
`default_nettype none

`include "rom_check_config.svh"

module digest_matcher import rom_check_pkg::*; (
  input  wire logic                                clk_i,
  input  wire logic                                rst_ni,
  input  wire logic                                checking_i,
  input  wire logic [`ROM_CHECK_CNT_W-1:0]         idx_i,
  input  wire logic [`ROM_CHECK_NUM_WORDS*32-1:0]  digest_i,
  input  wire logic [`ROM_CHECK_NUM_WORDS*32-1:0]  exp_digest_i,
  output mubi4_t                                   good_o
);

  logic [31:0] digest_word;
  logic [31:0] exp_word;
  logic        match_q;
  logic        checking_q;
  logic        finished;

  // Word pair at the current index
  assign digest_word = digest_i[{idx_i, 5'd0} +: 32];
  assign exp_word    = exp_digest_i[{idx_i, 5'd0} +: 32];

  // Match flag, starts true
  always_ff @(posedge clk_i or posedge rst_ni) begin
    if (rst_ni) begin
      match_q <= 1'b1;
    end else if (checking_i) begin
      match_q <= match_q & (digest_word == exp_word);
    end
  end

  // Falling edge of checking marks the end
  always_ff @(posedge clk_i or posedge rst_ni) begin
    if (rst_ni) begin
      checking_q <= 1'b0;
    end else begin
      checking_q <= checking_i;
    end
  end

  assign finished = checking_q & ~checking_i;

  // Result latched once, false until then
  always_ff @(posedge clk_i or posedge rst_ni) begin
    if (rst_ni) begin
      good_o <= MuBi4False;
    end else if (finished) begin
      good_o <= match_q ? MuBi4True : MuBi4False;
    end
  end

endmodule

`default_nettype wire

// ==== logic/word_counter.sv ====
/*
 * Redundant word index counter
 * Up-count plus inverted shadow, error when they stop being complements
 */

`timescale 1ns/100ps
`default_nettype none

`include "rom_check_config.svh"

module word_counter (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  input  wire logic                        incr_i,
  output logic [`ROM_CHECK_CNT_W-1:0]      idx_o,
  output logic                             err_o
);

  localparam int          CntW    = `ROM_CHECK_CNT_W;
  localparam int unsigned LastInt = `ROM_CHECK_NUM_WORDS - 1;
  localparam logic [CntW-1:0] LastIdx = LastInt[CntW-1:0];

  logic [CntW-1:0] idx_q;
  logic [CntW-1:0] idx_inv_q;
  logic [CntW-1:0] idx_nxt;

  assign idx_nxt = idx_q + 1'b1;

  // Both copies move together
  always_ff @(posedge clk_i or posedge rst_ni) begin
    if (rst_ni) begin
      idx_q     <= '0;
      idx_inv_q <= '1;
    end else if (incr_i && idx_q != LastIdx) begin
      // Holds at the last word
      idx_q     <= idx_nxt;
      idx_inv_q <= ~idx_nxt;
    end
  end

  assign idx_o = idx_q;
  // Fault on any bit where the copies agree
  assign err_o = (idx_q != ~idx_inv_q);

endmodule

`default_nettype wire

// ==== logic/compare_fsm.sv ====
/*
 * Sparse-encoded checker sequencer
 * Steps Waiting, Checking, Done and flags control-flow inconsistencies
 */

`timescale 1ns/100ps
`default_nettype none

`include "rom_check_config.svh"

module compare_fsm import rom_check_pkg::*; (
  input  wire logic                        clk_i,
  input  wire logic                        rst_ni,
  input  wire logic                        start_i,
  input  wire logic [`ROM_CHECK_CNT_W-1:0] idx_i,
  input  wire logic                        cnt_err_i,
  output logic                             incr_o,
  output logic                             checking_o,
  output logic                             done_o,
  output logic                             alert_o
);

  localparam int          CntW    = `ROM_CHECK_CNT_W;
  localparam int unsigned LastInt = `ROM_CHECK_NUM_WORDS - 1;
  localparam logic [CntW-1:0] LastIdx = LastInt[CntW-1:0];

  check_state_e state_q, state_d;
  logic         fsm_err;
  logic         start_err;
  logic         wait_idx_err;
  logic         done_idx_err;
  logic         at_last;

  assign at_last = (idx_i == LastIdx);

  // Next state, Done is final
  always_comb begin
    state_d = state_q;
    fsm_err = 1'b0;
    case (state_q)
      Waiting: begin
        if (start_i) begin
          state_d = Checking;
        end
      end
      Checking: begin
        if (at_last) begin
          state_d = Done;
        end
      end
      Done: begin
        state_d = Done;
      end
      // Any other code is a fault
      default: fsm_err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i or posedge rst_ni) begin
    if (rst_ni) begin
      state_q <= Waiting;
    end else begin
      state_q <= state_d;
    end
  end

  // Start only legal while Waiting
  assign start_err    = start_i & (state_q != Waiting);
  // Index must sit at zero before checking, at the last word after
  assign wait_idx_err = (state_q == Waiting) & (idx_i != '0);
  assign done_idx_err = (state_q == Done) & ~at_last;

  // Sticky alert
  always_ff @(posedge clk_i or posedge rst_ni) begin
    if (rst_ni) begin
      alert_o <= 1'b0;
    end else if (fsm_err | start_err | wait_idx_err | done_idx_err | cnt_err_i) begin
      alert_o <= 1'b1;
    end
  end

  assign checking_o = (state_q == Checking);
  assign done_o     = (state_q == Done);
  // Advance every Checking cycle but the last
  assign incr_o     = checking_o & ~at_last;

endmodule

`default_nettype wire

// ==== logic/rom_check_regs.sv ====
/*
 * APB register block of the ROM digest checker
 * Holds DIGEST and EXP_DIGEST words, decodes the start bit, returns status
 */

`timescale 1ns/100ps
`default_nettype none

`include "rom_check_config.svh"

module rom_check_regs import rom_check_pkg::*; (
  input  wire logic                             clk_i,
  input  wire logic                             rst_ni,
  input  wire logic [`ROM_CHECK_ADDR_W-1:0]     paddr_i,
  input  wire logic                             psel_i,
  input  wire logic                             penable_i,
  input  wire logic                             pwrite_i,
  input  wire logic [31:0]                      pwdata_i,
  output logic      [31:0]                      prdata_o,
  output logic                                  pready_o,
  output logic                                  pslverr_o,
  input  wire logic                             done_i,
  input  wire mubi4_t                           good_i,
  input  wire logic                             alert_i,
  output logic                                  start_o,
  output logic [`ROM_CHECK_NUM_WORDS*32-1:0]    digest_o,
  output logic [`ROM_CHECK_NUM_WORDS*32-1:0]    exp_digest_o
);

  localparam int NumWords = `ROM_CHECK_NUM_WORDS;
  localparam int CntW     = `ROM_CHECK_CNT_W;
  localparam int AddrW    = `ROM_CHECK_ADDR_W;
  // Byte span of one word array
  localparam int ArrBytes = 4 * NumWords;

  logic [31:0]      digest_q [NumWords];
  logic [31:0]      exp_q    [NumWords];
  logic             access;
  logic             wr_en;
  reg_sel_e         reg_sel;
  logic [AddrW-1:0] dig_offs;
  logic [AddrW-1:0] exp_offs;
  logic [CntW-1:0]  dig_idx;
  logic [CntW-1:0]  exp_idx;

  // Access phase, no wait states
  assign access   = psel_i & penable_i;
  assign wr_en    = access & pwrite_i;
  assign pready_o = 1'b1;

  // Byte offsets inside each word array
  assign dig_offs = paddr_i - `ROM_CHECK_DIGEST_OFFS;
  assign exp_offs = paddr_i - `ROM_CHECK_EXP_OFFS;
  assign dig_idx  = dig_offs[CntW+1:2];
  assign exp_idx  = exp_offs[CntW+1:2];

  // Address decode
  always_comb begin
    reg_sel = RegNone;
    if (paddr_i == `ROM_CHECK_CTRL_OFFS) begin
      reg_sel = RegCtrl;
    end else if (paddr_i == `ROM_CHECK_STATUS_OFFS) begin
      reg_sel = RegStatus;
    end else if (paddr_i >= `ROM_CHECK_DIGEST_OFFS && int'(dig_offs) < ArrBytes &&
                 paddr_i[1:0] == 2'b00) begin
      reg_sel = RegDigest;
    end else if (paddr_i >= `ROM_CHECK_EXP_OFFS && int'(exp_offs) < ArrBytes &&
                 paddr_i[1:0] == 2'b00) begin
      reg_sel = RegExpDigest;
    end
  end

  // Error only for unmapped offsets
  assign pslverr_o = access & (reg_sel == RegNone);

  // Digest word storage
  always_ff @(posedge clk_i or posedge rst_ni) begin
    if (rst_ni) begin
      for (int i = 0; i < NumWords; i++) begin
        digest_q[i] <= '0;
        exp_q[i]    <= '0;
      end
    end else if (wr_en) begin
      if (reg_sel == RegDigest) begin
        digest_q[dig_idx] <= pwdata_i;
      end
      if (reg_sel == RegExpDigest) begin
        exp_q[exp_idx] <= pwdata_i;
      end
    end
  end

  // One-cycle start pulse after CTRL write with bit 0
  always_ff @(posedge clk_i or posedge rst_ni) begin
    if (rst_ni) begin
      start_o <= 1'b0;
    end else begin
      start_o <= wr_en & (reg_sel == RegCtrl) & pwdata_i[0];
    end
  end

  // Flatten arrays, word 0 at the bottom
  always_comb begin
    for (int i = 0; i < NumWords; i++) begin
      digest_o[i*32 +: 32]     = digest_q[i];
      exp_digest_o[i*32 +: 32] = exp_q[i];
    end
  end

  // Read mux
  always_comb begin
    case (reg_sel)
      RegStatus:    prdata_o = {23'b0, alert_i, good_i, 3'b0, done_i};
      RegDigest:    prdata_o = digest_q[dig_idx];
      RegExpDigest: prdata_o = exp_q[exp_idx];
      // CTRL reads back as zero
      default:      prdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/rom_check_pkg.sv ====
/*
 * ROM digest checker package
 * Sequencer state encoding, register selects and multi-bit boolean
 */

`default_nettype none

package rom_check_pkg;

  // Sparse sequencer encoding
  // Pairwise Hamming distance 3 or 4
  typedef enum logic [4:0] {
    Waiting  = 5'b00100,
    Checking = 5'b10010,
    Done     = 5'b11001
  } check_state_e;

  // Decoded APB target
  typedef enum logic [2:0] {
    RegCtrl,
    RegStatus,
    RegDigest,
    RegExpDigest,
    RegNone
  } reg_sel_e;

  // Multi-bit boolean, every other code is invalid
  typedef logic [3:0] mubi4_t;

  parameter mubi4_t MuBi4True  = 4'h6;
  parameter mubi4_t MuBi4False = 4'h9;

endpackage

`default_nettype wire

// ==== include/rom_check_config.svh ====
/*
 * ROM digest checker configuration
 * Word count, APB address width and register map offsets
 */

`ifndef ROM_CHECK_CONFIG_SVH
`define ROM_CHECK_CONFIG_SVH

// Number of 32-bit digest words, at least 1
`define ROM_CHECK_NUM_WORDS 2

// Word index width, never below 1 bit
`define ROM_CHECK_CNT_W ((`ROM_CHECK_NUM_WORDS > 1) ? $clog2(`ROM_CHECK_NUM_WORDS) : 1)

// APB address width
`define ROM_CHECK_ADDR_W 8

// Register map
`define ROM_CHECK_CTRL_OFFS   8'h00
`define ROM_CHECK_STATUS_OFFS 8'h04
`define ROM_CHECK_DIGEST_OFFS 8'h10
`define ROM_CHECK_EXP_OFFS    8'h40

`endif
